// ==== bp_config.svh ====
`ifndef BP_CONFIG_SVH
`define BP_CONFIG_SVH

// Table geometry
// The row is selected by PC bits [BP_INDEX_BITS+1:2]
`define BP_INDEX_BITS 7

// Upper PC bits kept per row to tell aliasing branches apart
`define BP_TAG_BITS (32 - `BP_INDEX_BITS - 2)

// Number of rows in the direct-mapped table
`define BP_ROWS (1 << `BP_INDEX_BITS)

// Resolve queue entries
// Also the number of credits the execute side starts with
`define BP_RQ_DEPTH 4

// Width of every statistics counter
`define BP_STAT_BITS 16

// Fetch reset vector
`define BP_RESET_PC 32'h0000_0000

// Instruction size in bytes, sequential fetch step
`define BP_INSTR_BYTES 32'd4

`endif

// ==== bp_pkg.sv ====
`include "bp_config.svh"

package bp_pkg;

	// Two-bit saturating counter, upper bit means predict taken
	typedef enum logic [1:0] {
		STRONG_NT = 2'b00,
		WEAK_NT   = 2'b01,
		WEAK_T    = 2'b10,
		STRONG_T  = 2'b11
	} bp_ctr_e;

	// One branch resolved in execute
	typedef struct packed {
		logic        valid;
		logic [31:0] pc;
		logic        taken;
		logic [31:0] target; // Only meaningful when taken
	} bp_resolve_t;

	// Lookup result for the current fetch PC
	typedef struct packed {
		logic        hit;
		logic        taken;
		logic [31:0] next_pc;
	} bp_pred_t;

	// Performance counters
	typedef struct packed {
		logic [`BP_STAT_BITS-1:0] pred_taken;
		logic [`BP_STAT_BITS-1:0] pred_not_taken;
		logic [`BP_STAT_BITS-1:0] resolved_taken;
		logic [`BP_STAT_BITS-1:0] redirects;
	} bp_stats_t;

endpackage

// ==== bp_table.sv ====
`include "bp_config.svh"

module bp_table (
	input  logic                clk_i,
	input  logic                rst_i,
	input  logic [31:0]         lookup_pc_i,
	output bp_pkg::bp_pred_t    pred_o,
	input  bp_pkg::bp_resolve_t update_i
);

	localparam int ROWS = `BP_ROWS;
	localparam int IDX_W = `BP_INDEX_BITS;
	localparam int TAG_W = `BP_TAG_BITS;

	logic [ROWS-1:0]    valid_q;
	logic [TAG_W-1:0]   tag_q [ROWS];
	bp_pkg::bp_ctr_e    ctr_q [ROWS];
	logic [31:0]        target_q [ROWS];

	logic [IDX_W-1:0]   rd_idx;
	logic [TAG_W-1:0]   rd_tag;
	logic [1:0]         rd_ctr;
	logic               rd_hit;

	logic [IDX_W-1:0]   wr_idx;
	logic [TAG_W-1:0]   wr_tag;
	logic               wr_match;
	bp_pkg::bp_ctr_e    wr_ctr;

	// One step toward STRONG_T or STRONG_NT, sticking at the ends
	function automatic bp_pkg::bp_ctr_e ctr_step(input bp_pkg::bp_ctr_e cur,
			input logic taken);
		bp_pkg::bp_ctr_e nxt;
		nxt = cur;
		case (cur)
			bp_pkg::STRONG_NT: nxt = taken ? bp_pkg::WEAK_NT : bp_pkg::STRONG_NT;
			bp_pkg::WEAK_NT:   nxt = taken ? bp_pkg::WEAK_T : bp_pkg::STRONG_NT;
			bp_pkg::WEAK_T:    nxt = taken ? bp_pkg::STRONG_T : bp_pkg::WEAK_NT;
			bp_pkg::STRONG_T:  nxt = taken ? bp_pkg::STRONG_T : bp_pkg::WEAK_T;
			default:           nxt = bp_pkg::STRONG_NT;
		endcase
		return nxt;
	endfunction

	// Lookup side
	assign rd_idx = lookup_pc_i[IDX_W+1:2];
	assign rd_tag = lookup_pc_i[31:IDX_W+2];
	assign rd_ctr = ctr_q[rd_idx];
	assign rd_hit = valid_q[rd_idx] && (tag_q[rd_idx] == rd_tag);

	always_comb begin
		pred_o.hit = rd_hit;
		pred_o.taken = rd_hit && rd_ctr[1]; // Upper bit predicts taken
		if (pred_o.taken) begin
			pred_o.next_pc = target_q[rd_idx];
		end else begin
			pred_o.next_pc = lookup_pc_i + `BP_INSTR_BYTES;
		end
	end

	// Update side
	assign wr_idx = update_i.pc[IDX_W+1:2];
	assign wr_tag = update_i.pc[31:IDX_W+2];
	assign wr_match = valid_q[wr_idx] && (tag_q[wr_idx] == wr_tag);

	always_comb begin
		if (wr_match) begin
			wr_ctr = ctr_step(ctr_q[wr_idx], update_i.taken);
		end else if (update_i.taken) begin
			wr_ctr = bp_pkg::WEAK_T; // Fresh entry, leaning taken
		end else begin
			wr_ctr = bp_pkg::STRONG_NT;
		end
	end

	always_ff @(posedge clk_i) begin
		if (!rst_i) begin
			valid_q <= '0;
		end else if (update_i.valid) begin
			valid_q[wr_idx] <= 1'b1;
		end
	end

	// Row payload, meaningless until the valid bit is set
	always_ff @(posedge clk_i) begin
		if (update_i.valid) begin
			tag_q[wr_idx] <= wr_tag;
			ctr_q[wr_idx] <= wr_ctr;
			if (update_i.taken) begin
				target_q[wr_idx] <= update_i.target;
			end
		end
	end

	// An X on the resolve PC would corrupt an arbitrary row
	a_update_pc_known: assert property (
		@(posedge clk_i) disable iff (!rst_i)
		update_i.valid |-> !$isunknown(update_i.pc)
	) else $error("bp_table: update with unknown PC");

endmodule

// ==== bp_resolve_queue.sv ====
`include "bp_config.svh"

module bp_resolve_queue (
	input  logic                clk_i,
	input  logic                rst_i,
	input  bp_pkg::bp_resolve_t push_i,
	output bp_pkg::bp_resolve_t pop_o,
	output logic                credit_o
);

	localparam int DEPTH = `BP_RQ_DEPTH;
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	bp_pkg::bp_resolve_t mem_q [DEPTH];
	logic [PTR_W-1:0]    wr_ptr_q;
	logic [PTR_W-1:0]    rd_ptr_q;
	logic [CNT_W-1:0]    count_q;
	logic                credit_q;

	logic                empty;
	logic                full;
	logic                push;
	logic                pop;

	// Wrap at DEPTH, which need not be a power of two
	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
		if (ptr == PTR_W'(DEPTH - 1)) begin
			return '0;
		end
		return ptr + PTR_W'(1);
	endfunction

	assign empty = (count_q == '0);
	assign full = (count_q == CNT_W'(DEPTH));
	assign push = push_i.valid;
	assign pop = !empty; // Table never stalls, drain every cycle

	always_comb begin
		pop_o = mem_q[rd_ptr_q];
		pop_o.valid = pop;
	end

	always_ff @(posedge clk_i) begin
		if (push) begin
			mem_q[wr_ptr_q] <= push_i;
		end
	end

	always_ff @(posedge clk_i) begin
		if (!rst_i) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q <= '0;
			credit_q <= 1'b0;
		end else begin
			if (push) wr_ptr_q <= ptr_inc(wr_ptr_q);
			if (pop) rd_ptr_q <= ptr_inc(rd_ptr_q);
			case ({push, pop})
				2'b10:   count_q <= count_q + CNT_W'(1);
				2'b01:   count_q <= count_q - CNT_W'(1);
				default: count_q <= count_q;
			endcase
			credit_q <= pop; // One credit back per popped entry
		end
	end

	assign credit_o = credit_q;

	// A sender that respects its credits never gets here, since a
	// credit comes back only the cycle after its entry has left
	a_no_overflow: assert property (
		@(posedge clk_i) disable iff (!rst_i)
		push_i.valid |-> !full
	) else $error("bp_resolve_queue: push while full, credit protocol broken");

endmodule

// ==== bp_stats.sv ====
`include "bp_config.svh"

module bp_stats (
	input  logic                clk_i,
	input  logic                rst_i,
	input  logic                fetch_valid_i,
	input  bp_pkg::bp_pred_t    pred_i,
	input  bp_pkg::bp_resolve_t resolve_i,
	input  logic                redirect_i,
	output bp_pkg::bp_stats_t   stats_o
);

	localparam int W = `BP_STAT_BITS;

	bp_pkg::bp_stats_t stats_q;

	// Count up by one, hold at all ones
	function automatic logic [W-1:0] sat_inc(input logic [W-1:0] val, input logic en);
		if (en && (val != '1)) begin
			return val + W'(1);
		end
		return val;
	endfunction

	always_ff @(posedge clk_i) begin
		if (!rst_i) begin
			stats_q <= '0;
		end else begin
			stats_q.pred_taken <= sat_inc(stats_q.pred_taken,
				fetch_valid_i && pred_i.taken);
			stats_q.pred_not_taken <= sat_inc(stats_q.pred_not_taken,
				fetch_valid_i && !pred_i.taken);
			stats_q.resolved_taken <= sat_inc(stats_q.resolved_taken,
				resolve_i.valid && resolve_i.taken); // Seen at the table write
			stats_q.redirects <= sat_inc(stats_q.redirects, redirect_i);
		end
	end

	assign stats_o = stats_q;

endmodule

// ==== bp_fetch_pc.sv ====
`include "bp_config.svh"

module bp_fetch_pc (
	input  logic             clk_i,
	input  logic             rst_i,
	input  logic             fetch_en_i,
	input  logic             redirect_i,
	input  logic [31:0]      redirect_pc_i,
	input  bp_pkg::bp_pred_t pred_i,
	output logic [31:0]      pc_o
);

	logic [31:0] pc_q;
	logic [31:0] pc_d;
	logic        pc_load;

	// Execute knows better than the table
	always_comb begin
		if (redirect_i) begin
			pc_d = redirect_pc_i;
		end else begin
			pc_d = pred_i.next_pc;
		end
	end

	assign pc_load = redirect_i || fetch_en_i; // Otherwise hold the PC

	always_ff @(posedge clk_i) begin
		if (!rst_i) begin
			pc_q <= `BP_RESET_PC;
		end else if (pc_load) begin
			pc_q <= pc_d;
		end
	end

	assign pc_o = pc_q;

	// Table lookup drops PC[1:0], so a misaligned target would alias
	a_redirect_aligned: assert property (
		@(posedge clk_i) disable iff (!rst_i)
		redirect_i |-> (redirect_pc_i[1:0] == 2'b00)
	) else $error("bp_fetch_pc: redirect to unaligned PC %h", redirect_pc_i);

endmodule

// ==== bp_top.sv ====
`include "bp_config.svh"

module bp_top (
	input  logic                clk_i,
	input  logic                rst_i,
	input  logic                fetch_en_i,
	input  logic                redirect_i,
	input  logic [31:0]         redirect_pc_i,
	input  bp_pkg::bp_resolve_t resolve_i,
	output logic                credit_o,
	output logic [31:0]         pc_o,
	output bp_pkg::bp_pred_t    pred_o,
	output bp_pkg::bp_stats_t   stats_o
);

	bp_pkg::bp_resolve_t rq_head; // Popped entry, straight into the table
	bp_pkg::bp_pred_t    pred;
	logic [31:0]         fetch_pc;

	bp_resolve_queue u_resolve_queue (
		.clk_i    (clk_i),
		.rst_i    (rst_i),
		.push_i   (resolve_i),
		.pop_o    (rq_head),
		.credit_o (credit_o)
	);

	bp_table u_table (
		.clk_i       (clk_i),
		.rst_i       (rst_i),
		.lookup_pc_i (fetch_pc),
		.pred_o      (pred),
		.update_i    (rq_head)
	);

	bp_fetch_pc u_fetch_pc (
		.clk_i         (clk_i),
		.rst_i         (rst_i),
		.fetch_en_i    (fetch_en_i),
		.redirect_i    (redirect_i),
		.redirect_pc_i (redirect_pc_i),
		.pred_i        (pred),
		.pc_o          (fetch_pc)
	);

	bp_stats u_stats (
		.clk_i         (clk_i),
		.rst_i         (rst_i),
		.fetch_valid_i (fetch_en_i),
		.pred_i        (pred),
		.resolve_i     (rq_head),
		.redirect_i    (redirect_i),
		.stats_o       (stats_o)
	);

	assign pc_o = fetch_pc;
	assign pred_o = pred;

endmodule

// ==== bp_tb.sv ====
`include "bp_config.svh"

module bp_tb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int IDX_W = `BP_INDEX_BITS;
	localparam int TAG_W = `BP_TAG_BITS;
	localparam int ROWS = `BP_ROWS;
	localparam int DEPTH = `BP_RQ_DEPTH;

	typedef enum logic [1:0] {ROW_RESOLVE, ROW_FETCH, ROW_REDIRECT, ROW_WAIT} row_kind_e;

	// Resolve rows use exp as "wait out the queue latency", fetch rows as expected taken,
	// wait rows as total credits returned, redirect rows use taken as "fetch_en too"
	typedef struct packed {
		row_kind_e   kind;
		logic [31:0] pc;
		logic        taken;
		logic [31:0] target;
		logic [31:0] exp;
	} row_t;

	logic                clk_i;
	logic                rst_i;
	logic                fetch_en_i;
	logic                redirect_i;
	logic [31:0]         redirect_pc_i;
	bp_pkg::bp_resolve_t resolve_i;
	logic                credit_o;
	logic [31:0]         pc_o;
	bp_pkg::bp_pred_t    pred_o;
	bp_pkg::bp_stats_t   stats_o;

	row_t        rows [$];
	string       row_names [$];
	logic        ref_valid [ROWS];
	logic [TAG_W-1:0] ref_tag [ROWS];
	int          ref_ctr [ROWS];
	logic [31:0] ref_tgt [ROWS];
	logic [31:0] exp_pc;
	int          spent;
	int          returned; // Credits counted back from credit_o
	int          cycles;
	int          cycle_limit = 1000;
	int          n_pred_taken;
	int          n_pred_nt;
	int          n_res_taken;
	int          n_redirects;

	bp_top u_bp_top (
		.clk_i         (clk_i),
		.rst_i         (rst_i),
		.fetch_en_i    (fetch_en_i),
		.redirect_i    (redirect_i),
		.redirect_pc_i (redirect_pc_i),
		.resolve_i     (resolve_i),
		.credit_o      (credit_o),
		.pc_o          (pc_o),
		.pred_o        (pred_o),
		.stats_o       (stats_o)
	);

	initial begin
		clk_i = 1'b0;
		forever #20 clk_i = ~clk_i;
	end

	always @(posedge clk_i) begin
		if (rst_i && credit_o) returned <= returned + 1;
	end

	always @(posedge clk_i) begin
		cycles <= cycles + 1;
		if (cycles >= cycle_limit) begin
			$display("Timeout: the run did not finish within %0d cycles", cycle_limit);
			$display("Errors found");
			$fatal(1, "simulation stopped on timeout");
		end
	end

	task automatic check_value(input string name, input logic [31:0] exp,
			input logic [31:0] act);
		if (act !== exp) begin
			$display("Error: %s expected %h actual %h", name, exp, act);
			$display("Errors found");
			$fatal(1, "stopping at first mismatch");
		end
	endtask

	function automatic void add_row(input string name, input row_kind_e kind,
			input logic [31:0] pc, input logic taken, input logic [31:0] target,
			input logic [31:0] exp);
		row_t r;
		r.kind = kind;
		r.pc = pc;
		r.taken = taken;
		r.target = target;
		r.exp = exp;
		rows.push_back(r);
		row_names.push_back(name);
	endfunction

	// Word aligned random PC forced onto a chosen row
	function automatic logic [31:0] rand_pc(input int row);
		logic [31:0] v;
		v = $urandom;
		v[IDX_W+1:2] = IDX_W'(row);
		v[1:0] = 2'b00;
		return v;
	endfunction

	// Reference bimodal table
	function automatic bp_pkg::bp_pred_t lookup_model(input logic [31:0] pc);
		bp_pkg::bp_pred_t p;
		int idx;
		idx = pc[IDX_W+1:2];
		p.hit = ref_valid[idx] && (ref_tag[idx] == pc[31:IDX_W+2]);
		p.taken = p.hit && (ref_ctr[idx] >= 2);
		p.next_pc = p.taken ? ref_tgt[idx] : pc + 32'd4;
		return p;
	endfunction

	function automatic void update_model(input logic [31:0] pc, input logic taken,
			input logic [31:0] target);
		int idx;
		idx = pc[IDX_W+1:2];
		if (ref_valid[idx] && (ref_tag[idx] == pc[31:IDX_W+2])) begin
			if (taken && ref_ctr[idx] < 3) ref_ctr[idx]++;
			if (!taken && ref_ctr[idx] > 0) ref_ctr[idx]--;
		end else begin
			ref_valid[idx] = 1'b1; // New owner of the row
			ref_tag[idx] = pc[31:IDX_W+2];
			ref_ctr[idx] = taken ? 2 : 0;
		end
		if (taken) ref_tgt[idx] = target;
	endfunction

	task automatic drive_idle();
		fetch_en_i <= 1'b0;
		redirect_i <= 1'b0;
		resolve_i <= '0;
	endtask

	initial begin
		bp_pkg::bp_pred_t    pred;
		bp_pkg::bp_resolve_t upd;
		logic [31:0]         a_pc;
		logic [31:0]         alias_pc;
		logic [31:0]         burst_pc [4];
		void'($urandom(43));
		rst_i <= 1'b0;
		redirect_pc_i <= '0;
		drive_idle();
		for (int i = 0; i < ROWS; i++) ref_valid[i] = 1'b0;
		a_pc = 32'h0000_1040;
		alias_pc = a_pc ^ (32'd1 << (IDX_W + 2)); // Same row, other tag
		for (int k = 0; k < 4; k++) burst_pc[k] = rand_pc(32 + k);

		add_row("reset fetch 0", ROW_FETCH, 0, 0, 0, 0);
		add_row("reset fetch 1", ROW_FETCH, 0, 0, 0, 0);
		add_row("reset fetch 2", ROW_FETCH, 0, 0, 0, 0);
		add_row("alloc A", ROW_RESOLVE, a_pc, 1, 32'h0000_2000, 1);
		add_row("goto A", ROW_REDIRECT, a_pc, 0, 0, 0);
		add_row("fetch A weak taken", ROW_FETCH, 0, 0, 0, 1);
		add_row("fetch T", ROW_FETCH, 0, 0, 0, 0);
		add_row("A taken", ROW_RESOLVE, a_pc, 1, 32'h0000_2000, 1);
		add_row("A not taken 1", ROW_RESOLVE, a_pc, 0, 0, 1);
		add_row("goto A 2", ROW_REDIRECT, a_pc, 0, 0, 0);
		add_row("hysteresis taken", ROW_FETCH, 0, 0, 0, 1);
		add_row("A not taken 2", ROW_RESOLVE, a_pc, 0, 0, 1);
		add_row("goto A 3", ROW_REDIRECT, a_pc, 0, 0, 0);
		add_row("hysteresis not taken", ROW_FETCH, 0, 0, 0, 0);
		add_row("alias alloc", ROW_RESOLVE, alias_pc, 1, 32'h0000_4000, 1);
		add_row("goto A 4", ROW_REDIRECT, a_pc, 0, 0, 0);
		add_row("old PC misses", ROW_FETCH, 0, 0, 0, 0);
		add_row("goto alias", ROW_REDIRECT, alias_pc, 0, 0, 0);
		add_row("redirect beats taken", ROW_REDIRECT, 32'h0000_3000, 1, 0, 0);
		add_row("fetch B", ROW_FETCH, 0, 0, 0, 0);
		for (int k = 0; k < 4; k++) begin
			add_row($sformatf("burst %0d", k), ROW_RESOLVE, burst_pc[k], 1,
				$urandom & 32'hffff_fffc, (k == 3) ? 1 : 0);
		end
		add_row("credits back", ROW_WAIT, 0, 0, 0, 9);
		add_row("goto burst 0", ROW_REDIRECT, burst_pc[0], 0, 0, 0);
		add_row("fetch burst 0", ROW_FETCH, 0, 0, 0, 1);
		cycle_limit = rows.size() * 8 + 50;

		exp_pc = `BP_RESET_PC;
		repeat (3) @(posedge clk_i);
		rst_i <= 1'b1;

		foreach (rows[i]) begin
			@(posedge clk_i);
			drive_idle();
			case (rows[i].kind)
				ROW_FETCH, ROW_REDIRECT: begin
					if (rows[i].kind == ROW_REDIRECT) begin
						redirect_i <= 1'b1;
						redirect_pc_i <= rows[i].pc;
						fetch_en_i <= rows[i].taken;
					end else begin
						fetch_en_i <= 1'b1;
					end
					@(negedge clk_i);
					pred = lookup_model(exp_pc);
					check_value({row_names[i], " pc"}, exp_pc, pc_o);
					check_value({row_names[i], " hit"}, pred.hit, pred_o.hit);
					check_value({row_names[i], " next_pc"}, pred.next_pc, pred_o.next_pc);
					if (rows[i].kind == ROW_FETCH) begin
						check_value({row_names[i], " taken"}, rows[i].exp, pred_o.taken);
					end
					if (rows[i].kind == ROW_FETCH || rows[i].taken) begin
						if (pred.taken) n_pred_taken++;
						else n_pred_nt++;
					end
					if (rows[i].kind == ROW_REDIRECT) begin
						n_redirects++;
						exp_pc = rows[i].pc;
					end else begin
						exp_pc = pred.next_pc;
					end
				end
				ROW_RESOLVE: begin
					while (spent - returned >= DEPTH) @(posedge clk_i); // No credit left
					upd.valid = 1'b1;
					upd.pc = rows[i].pc;
					upd.taken = rows[i].taken;
					upd.target = rows[i].target;
					resolve_i <= upd;
					spent++;
					if (rows[i].taken) n_res_taken++;
					update_model(rows[i].pc, rows[i].taken, rows[i].target);
					if (rows[i].exp != 0) begin
						@(posedge clk_i);
						drive_idle();
						repeat (2) @(posedge clk_i); // Pop edge, then one more
					end
				end
				default: begin
					while (returned < spent) @(posedge clk_i);
					repeat (2) @(posedge clk_i);
					@(negedge clk_i);
					check_value({row_names[i], " count"}, rows[i].exp, returned);
				end
			endcase
		end

		@(posedge clk_i);
		drive_idle();
		repeat (2) @(posedge clk_i);
		@(negedge clk_i);
		check_value("final pc", exp_pc, pc_o);
		check_value("stats pred_taken", n_pred_taken, stats_o.pred_taken);
		check_value("stats pred_not_taken", n_pred_nt, stats_o.pred_not_taken);
		check_value("stats resolved_taken", n_res_taken, stats_o.resolved_taken);
		check_value("stats redirects", n_redirects, stats_o.redirects);
		$display("No errors");
		$finish;
	end

endmodule

// ==== src.f ====
+incdir+.
bp_pkg.sv
bp_table.sv
bp_resolve_queue.sv
bp_stats.sv
bp_fetch_pc.sv
bp_top.sv
bp_tb.sv

// ==== Bender.yml ====
package:
  name: bp_frontend

export_include_dirs:
  - .

sources:
  - bp_pkg.sv
  - bp_table.sv
  - bp_resolve_queue.sv
  - bp_stats.sv
  - bp_fetch_pc.sv
  - bp_top.sv
  - target: test
    files:
      - bp_tb.sv
